// File: sources.f
+incdir+.
video_pkg.sv
video_timing_gen.sv
video_pattern_gen.sv
video_subsys_top.sv
video_checker.sv
tb_video_top.sv

// File: tb_video_top.sv
`default_nettype none

module tb_video_top;

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // small mode, 46 x 15 = 690 clocks per frame
    // --------------------------------------------------

    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 6;
    localparam int H_DISP       = 32;
    localparam int H_FRONT      = 4;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 3;
    localparam int V_DISP       = 8;
    localparam int V_FRONT      = 2;
    localparam int H_TOTAL      = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL      = V_SYNC + V_BACK + V_DISP + V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;  // bound for any single wait
    localparam int BAR_W        = H_DISP / 8;        // 4 pixels per bar here

    // white yellow cyan green magenta red blue black
    localparam logic [15:0] BAR_TABLE [8] = '{
        16'hFFFF, 16'hFFE0, 16'h07FF, 16'h07E0, 16'hF81F, 16'hF800, 16'h001F, 16'h0000
    };

    logic                     pixel_clk;
    logic                     sys_rst_n;
    video_pkg::pattern_mode_e pattern_mode;
    video_pkg::rgb565_t       solid_color;
    video_pkg::video_out_t    video;
    video_pkg::rgb565_t       colour_a;  // random solid colours
    video_pkg::rgb565_t       colour_b;

    video_subsys_top #(
        .H_SYNC (H_SYNC), .H_BACK (H_BACK), .H_DISP (H_DISP), .H_FRONT (H_FRONT),
        .V_SYNC (V_SYNC), .V_BACK (V_BACK), .V_DISP (V_DISP), .V_FRONT (V_FRONT)
    ) u_dut (
        .pixel_clk    (pixel_clk),
        .sys_rst_n    (sys_rst_n),
        .pattern_mode (pattern_mode),
        .solid_color  (solid_color),
        .video        (video)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #5 pixel_clk = ~pixel_clk;  // 100 MHz
    end

    // --------------------------------------------------
    // reporting and compare
    // --------------------------------------------------

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_rgb(input string name, input video_pkg::rgb565_t exp,
                               input video_pkg::rgb565_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_with_failure($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // --------------------------------------------------
    // reference model and stimulus helpers
    // --------------------------------------------------

    function automatic video_pkg::rgb565_t expected_pixel(input int x, input int y,
            input video_pkg::pattern_mode_e mode, input video_pkg::rgb565_t colour);
        video_pkg::rgb565_t p;
        int                 bar;
        bar = (x / BAR_W > 7) ? 7 : x / BAR_W;  // capped at black
        case (mode)
            video_pkg::pat_color_bars: p = BAR_TABLE[bar];
            video_pkg::pat_gradient: begin
                p.r = 5'(x % 32);
                p.g = 6'(y % 64);
                p.b = 5'((x + y) % 32);
            end
            video_pkg::pat_grid: p = (x % 16 == 0 || y % 16 == 0) ? 16'hFFFF : 16'h0000;
            default:             p = colour;
        endcase
        return p;
    endfunction

    // new inputs land just after a rising edge
    task automatic drive_inputs(input video_pkg::pattern_mode_e mode,
                                input video_pkg::rgb565_t colour);
        @(posedge pixel_clk);
        #1;
        pattern_mode = mode;
        solid_color  = colour;
    endtask

    function automatic logic sync_level(input bit use_vs);
        return use_vs ? video.vs : video.hs;
    endfunction

    // outputs are sampled on falling edges, mid cycle
    task automatic wait_fall(input bit use_vs, input string what, output int waited);
        logic prev;
        logic cur;
        waited = 0;
        cur    = sync_level(use_vs);
        do begin
            prev = cur;
            @(negedge pixel_clk);
            waited++;
            cur = sync_level(use_vs);
            if (waited > WAIT_LIMIT) stop_with_failure({"timeout waiting for ", what, " to fall"});
        end while (!(prev && !cur));
    endtask

    task automatic count_low(input bit use_vs, input string what, output int width);
        width = 0;
        while (!sync_level(use_vs)) begin
            width++;
            if (width > WAIT_LIMIT) stop_with_failure({what, " stayed low too long"});
            @(negedge pixel_clk);
        end
    endtask

    // starts at a frame start, ends at the next one
    task automatic check_frame(input string name, input video_pkg::pattern_mode_e mode,
                               input video_pkg::rgb565_t colour, input int switch_line,
                               input video_pkg::pattern_mode_e next_mode,
                               input video_pkg::rgb565_t next_colour);
        int   x;
        int   y;
        int   since_hs;
        int   cycles;
        logic prev_de;
        logic prev_hs;
        logic prev_vs;
        logic line_done;
        x        = 0;
        y        = 0;
        since_hs = 0;  // frame start is also an hs fall
        cycles   = 0;
        prev_de  = 1'b0;
        prev_hs  = video.hs;
        while (y < V_DISP) begin
            @(negedge pixel_clk);
            cycles++;
            since_hs++;
            line_done = 1'b0;
            if (cycles > FRAME_CYCLES) stop_with_failure({name, " frame ended short of lines"});
            if (prev_hs && !video.hs) since_hs = 0;
            if (video.de && !prev_de) begin
                compare_count({name, " first de after hs"}, H_SYNC + H_BACK, since_hs);
                if (y == 0) begin
                    // first active line sits right after the back porch lines
                    compare_count({name, " first de of frame"},
                                  (V_SYNC + V_BACK) * H_TOTAL + H_SYNC + H_BACK, cycles);
                end
            end
            if (video.de) begin
                compare_rgb({name, " pixel"}, expected_pixel(x, y, mode, colour), video.rgb);
                x++;
            end else if (prev_de) begin
                compare_count({name, " de per line"}, H_DISP, x);
                x         = 0;
                y++;
                line_done = 1'b1;
            end
            prev_de = video.de;
            prev_hs = video.hs;
            if (line_done && y == switch_line) drive_inputs(next_mode, next_colour);
        end
        // no extra active line before the next frame
        cycles = 0;
        do begin
            prev_vs = video.vs;
            @(negedge pixel_clk);
            cycles++;
            compare_bit({name, " de in vertical blanking"}, 1'b0, video.de);
            if (cycles > WAIT_LIMIT) stop_with_failure({name, " next frame never started"});
        end while (!(prev_vs && !video.vs));
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic reset_state();
        int width;
        repeat (8) @(posedge pixel_clk);
        @(negedge pixel_clk);
        compare_bit("reset de", 1'b0, video.de);
        compare_rgb("reset rgb", '0, video.rgb);
        compare_bit("reset hs", 1'b0, video.hs);
        compare_bit("reset vs", 1'b0, video.vs);
        repeat (8) @(posedge pixel_clk);  // 16 cycles in all
        #1;
        sys_rst_n = 1'b1;
        @(negedge pixel_clk);
        count_low(1'b1, "vs", width);
        compare_count("reset vs low after release", V_SYNC * H_TOTAL, width);
    endtask

    task automatic sync_geometry();
        int waited;
        int width;
        wait_fall(1'b0, "hs", waited);
        count_low(1'b0, "hs", width);
        compare_count("sync hs low width", H_SYNC, width);
        wait_fall(1'b0, "hs", waited);
        compare_count("sync hs period", H_TOTAL, width + waited);
        wait_fall(1'b1, "vs", waited);
        count_low(1'b1, "vs", width);
        compare_count("sync vs low width", V_SYNC * H_TOTAL, width);
        wait_fall(1'b1, "vs", waited);  // leaves us at a frame start
        compare_count("sync frame period", FRAME_CYCLES, width + waited);
    endtask

    task automatic bars_and_gradient();
        check_frame("color_bars", video_pkg::pat_color_bars, '0, V_DISP,
                    video_pkg::pat_gradient, '0);
        check_frame("gradient", video_pkg::pat_gradient, '0, V_DISP,
                    video_pkg::pat_grid, '0);
    endtask

    task automatic grid_and_solid();
        check_frame("grid", video_pkg::pat_grid, '0, V_DISP, video_pkg::pat_solid, colour_a);
        check_frame("solid", video_pkg::pat_solid, colour_a, V_DISP,
                    video_pkg::pat_solid, colour_a);
    endtask

    // mode and colour change after line 4, must wait for the next frame
    task automatic frame_switch();
        check_frame("switch_old", video_pkg::pat_solid, colour_a, V_DISP / 2,
                    video_pkg::pat_color_bars, colour_b);
        check_frame("switch_new", video_pkg::pat_color_bars, colour_b, V_DISP,
                    video_pkg::pat_color_bars, colour_b);
    endtask

    initial begin
        sys_rst_n    = 1'b0;
        pattern_mode = video_pkg::pat_color_bars;
        solid_color  = '0;
        void'($urandom(32'h8b435307));
        colour_a = 16'($urandom());
        colour_b = 16'($urandom());
        reset_state();
        sync_geometry();
        bars_and_gradient();
        grid_and_solid();
        frame_switch();
        if (u_dut.u_checker.assert_fails != 0) begin
            stop_with_failure("video checker assertions failed during the run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: video_checker.sv
`default_nettype none

`include "video_config.svh"

module video_checker #(
    parameter int H_SYNC = `VID_H_SYNC
) (
    input wire logic                  pixel_clk,
    input wire logic                  sys_rst_n,
    input wire video_pkg::video_out_t video,
    input wire logic                  frame_start  // internal strobe of the top
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_fails = 0;  // failures so far

    // --------------------------------------------------
    // display side rules
    // --------------------------------------------------

    a_rgb_blank: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        !video.de |-> (video.rgb == '0)
    ) else begin
        assert_fails++;
        $error("rgb not zero while de is low");
    end

    // de only inside the sync-high region
    a_de_in_sync: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        video.de |-> (video.hs && video.vs)
    ) else begin
        assert_fails++;
        $error("de high during an hs or vs pulse");
    end

    a_hs_width: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        $fell(video.hs) |-> (!video.hs) [*H_SYNC] ##1 video.hs
    ) else begin
        assert_fails++;
        $error("hs low pulse has the wrong width");
    end

    // one clock at the top left corner, first one right after release
    a_frame_pulse: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        frame_start |=> !frame_start
    ) else begin
        assert_fails++;
        $error("frame_start longer than one cycle");
    end

endmodule

bind video_subsys_top video_checker #(
    .H_SYNC (H_SYNC)
) u_checker (
    .pixel_clk   (pixel_clk),
    .sys_rst_n   (sys_rst_n),
    .video       (video),
    .frame_start (frame_start)
);

`default_nettype wire

// File: video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// --------------------------------------------------
// coordinate and counter width
// --------------------------------------------------

// 11 bits covers totals up to 2047
`define VID_COORD_W 11

// --------------------------------------------------
// horizontal timing in pixel clocks
// --------------------------------------------------

// 1280x720 at 60 Hz, 74.25 MHz pixel clock
`define VID_H_SYNC  40    // sync pulse width
`define VID_H_BACK  220   // back porch
`define VID_H_DISP  1280  // visible pixels per line
`define VID_H_FRONT 110   // front porch

// --------------------------------------------------
// vertical timing in lines
// --------------------------------------------------

`define VID_V_SYNC  5     // sync pulse height
`define VID_V_BACK  20    // back porch
`define VID_V_DISP  720   // visible lines per frame
`define VID_V_FRONT 5     // front porch

// totals are not kept here
// each module sums the four parts itself

`endif

// File: video_pattern_gen.sv
`default_nettype none

`include "video_config.svh"

module video_pattern_gen #(
    parameter int H_SYNC  = `VID_H_SYNC,
    parameter int H_BACK  = `VID_H_BACK,
    parameter int H_DISP  = `VID_H_DISP,
    parameter int H_FRONT = `VID_H_FRONT,
    parameter int V_SYNC  = `VID_V_SYNC,
    parameter int V_BACK  = `VID_V_BACK,
    parameter int V_DISP  = `VID_V_DISP,
    parameter int V_FRONT = `VID_V_FRONT
) (
    input  wire logic                      pixel_clk,
    input  wire logic                      sys_rst_n,
    input  wire logic                      frame_start,   // latch strobe
    input  wire logic                      data_req,      // pixel wanted next clock
    input  wire video_pkg::pixel_pos_t     pixel_pos,     // which pixel
    input  wire video_pkg::pattern_mode_e  pattern_mode,  // raw, may change any time
    input  wire video_pkg::rgb565_t        solid_color,   // raw, may change any time
    output video_pkg::rgb565_t             pixel          // one clock after data_req
);

    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    // eight bars across the visible width
    localparam int BAR_W = H_DISP / 8;

    // coordinates arrive in coord_t, so the mode must fit
    if (H_TOTAL > (1 << $bits(video_pkg::coord_t)) ||
        V_TOTAL > (1 << $bits(video_pkg::coord_t))) begin : g_width_check
        $error("video_pattern_gen: timing totals do not fit the coordinate width");
    end

    // --------------------------------------------------
    // per-frame latch
    // --------------------------------------------------

    video_pkg::pattern_mode_e mode_q;
    video_pkg::rgb565_t       solid_q;

    // only sampled at frame start, no tearing mid-frame
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            mode_q  <= video_pkg::pat_color_bars;
            solid_q <= '0;
        end else if (frame_start) begin
            mode_q  <= pattern_mode;
            solid_q <= solid_color;
        end
    end

    // --------------------------------------------------
    // pattern terms
    // --------------------------------------------------

    logic [2:0]         bar_idx;   // 0 white .. 7 black
    video_pkg::coord_t  sum_xy;    // diagonal term for blue ramp
    logic               grid_on;   // on a grid line
    video_pkg::rgb565_t pix_nxt;   // value to register

    // bar colours in display order
    function automatic video_pkg::rgb565_t bar_color(input logic [2:0] idx);
        video_pkg::rgb565_t c;
        case (idx)
            3'd0:    c = video_pkg::rgb565_t'(16'hFFFF);  // white
            3'd1:    c = video_pkg::rgb565_t'(16'hFFE0);  // yellow
            3'd2:    c = video_pkg::rgb565_t'(16'h07FF);  // cyan
            3'd3:    c = video_pkg::rgb565_t'(16'h07E0);  // green
            3'd4:    c = video_pkg::rgb565_t'(16'hF81F);  // magenta
            3'd5:    c = video_pkg::rgb565_t'(16'hF800);  // red
            3'd6:    c = video_pkg::rgb565_t'(16'h001F);  // blue
            default: c = video_pkg::rgb565_t'(16'h0000);  // black
        endcase
        return c;
    endfunction

    // count bar edges already passed, constants fold per k
    always_comb begin
        bar_idx = '0;
        for (int k = 1; k < 8; k++) begin
            if (pixel_pos.x >= video_pkg::coord_t'(k * BAR_W)) begin
                bar_idx = 3'(k);
            end
        end
    end

    assign sum_xy  = pixel_pos.x + pixel_pos.y;
    assign grid_on = (pixel_pos.x[3:0] == 4'd0) || (pixel_pos.y[3:0] == 4'd0);

    // mode select
    always_comb begin
        case (mode_q)
            video_pkg::pat_color_bars: pix_nxt = bar_color(bar_idx);
            video_pkg::pat_gradient: begin
                pix_nxt.r = pixel_pos.x[4:0];
                pix_nxt.g = pixel_pos.y[5:0];
                pix_nxt.b = sum_xy[4:0];
            end
            video_pkg::pat_grid:       pix_nxt = grid_on ? '1 : '0;  // white on black
            default:                   pix_nxt = solid_q;
        endcase
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------

    // zero between requests keeps blanking black
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pixel <= '0;
        end else if (data_req) begin
            pixel <= pix_nxt;
        end else begin
            pixel <= '0;
        end
    end

endmodule

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

`include "video_config.svh"

package video_pkg;

    // --------------------------------------------------
    // coordinates
    // --------------------------------------------------

    // one counter or coordinate value
    typedef logic [`VID_COORD_W-1:0] coord_t;

    // requested pixel, relative to active area origin
    typedef struct packed {
        coord_t x;  // column
        coord_t y;  // row
    } pixel_pos_t;

    // --------------------------------------------------
    // colour and display bundle
    // --------------------------------------------------

    // 5/6/5 packing, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // what the panel sees
    typedef struct packed {
        logic    hs;   // active low
        logic    vs;   // active low
        logic    de;   // data enable
        rgb565_t rgb;  // zero outside de
    } video_out_t;

    // pattern select, sampled once per frame
    typedef enum logic [1:0] {
        pat_color_bars,  // eight vertical bars
        pat_gradient,    // x/y ramps
        pat_grid,        // 16 pixel grid
        pat_solid        // flat colour
    } pattern_mode_e;

endpackage

`default_nettype wire

// File: video_subsys_top.sv
`default_nettype none

`include "video_config.svh"

module video_subsys_top #(
    parameter int H_SYNC  = `VID_H_SYNC,
    parameter int H_BACK  = `VID_H_BACK,
    parameter int H_DISP  = `VID_H_DISP,
    parameter int H_FRONT = `VID_H_FRONT,
    parameter int V_SYNC  = `VID_V_SYNC,
    parameter int V_BACK  = `VID_V_BACK,
    parameter int V_DISP  = `VID_V_DISP,
    parameter int V_FRONT = `VID_V_FRONT
) (
    input  wire logic                      pixel_clk,
    input  wire logic                      sys_rst_n,
    input  wire video_pkg::pattern_mode_e  pattern_mode,
    input  wire video_pkg::rgb565_t        solid_color,
    output video_pkg::video_out_t          video         // to the panel
);

    logic                  hs;
    logic                  vs;
    logic                  de;
    logic                  data_req;     // timing to pattern, one clock early
    logic                  frame_start;  // timing to pattern, latch strobe
    video_pkg::pixel_pos_t pixel_pos;
    video_pkg::rgb565_t    pixel;        // arrives with de

    // --------------------------------------------------
    // timing and pattern source
    // --------------------------------------------------

    video_timing_gen #(
        .H_SYNC (H_SYNC), .H_BACK (H_BACK), .H_DISP (H_DISP), .H_FRONT (H_FRONT),
        .V_SYNC (V_SYNC), .V_BACK (V_BACK), .V_DISP (V_DISP), .V_FRONT (V_FRONT)
    ) u_timing (
        .pixel_clk   (pixel_clk),
        .sys_rst_n   (sys_rst_n),
        .hs          (hs),
        .vs          (vs),
        .de          (de),
        .data_req    (data_req),
        .pixel_pos   (pixel_pos),
        .frame_start (frame_start)
    );

    video_pattern_gen #(
        .H_SYNC (H_SYNC), .H_BACK (H_BACK), .H_DISP (H_DISP), .H_FRONT (H_FRONT),
        .V_SYNC (V_SYNC), .V_BACK (V_BACK), .V_DISP (V_DISP), .V_FRONT (V_FRONT)
    ) u_pattern (
        .pixel_clk    (pixel_clk),
        .sys_rst_n    (sys_rst_n),
        .frame_start  (frame_start),
        .data_req     (data_req),
        .pixel_pos    (pixel_pos),
        .pattern_mode (pattern_mode),
        .solid_color  (solid_color),
        .pixel        (pixel)
    );

    // bundle for the display side
    assign video = '{hs: hs, vs: vs, de: de, rgb: pixel};

endmodule

`default_nettype wire

// File: video_timing_gen.sv
`default_nettype none

`include "video_config.svh"

module video_timing_gen #(
    parameter int H_SYNC  = `VID_H_SYNC,
    parameter int H_BACK  = `VID_H_BACK,
    parameter int H_DISP  = `VID_H_DISP,
    parameter int H_FRONT = `VID_H_FRONT,
    parameter int V_SYNC  = `VID_V_SYNC,
    parameter int V_BACK  = `VID_V_BACK,
    parameter int V_DISP  = `VID_V_DISP,
    parameter int V_FRONT = `VID_V_FRONT
) (
    input  wire logic                  pixel_clk,
    input  wire logic                  sys_rst_n,
    output logic                       hs,           // active low
    output logic                       vs,           // active low
    output logic                       de,           // data_req one clock late
    output logic                       data_req,     // early pixel request
    output video_pkg::pixel_pos_t      pixel_pos,    // valid with data_req
    output logic                       frame_start   // both counters at zero
);

    // --------------------------------------------------
    // derived timing
    // --------------------------------------------------

    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    localparam video_pkg::coord_t H_SYNC_END = video_pkg::coord_t'(H_SYNC);
    localparam video_pkg::coord_t H_ACT_BEG  = video_pkg::coord_t'(H_SYNC + H_BACK);
    localparam video_pkg::coord_t H_ACT_END  = video_pkg::coord_t'(H_SYNC + H_BACK + H_DISP);
    localparam video_pkg::coord_t H_LAST     = video_pkg::coord_t'(H_TOTAL - 1);

    localparam video_pkg::coord_t V_SYNC_END = video_pkg::coord_t'(V_SYNC);
    localparam video_pkg::coord_t V_ACT_BEG  = video_pkg::coord_t'(V_SYNC + V_BACK);
    localparam video_pkg::coord_t V_ACT_END  = video_pkg::coord_t'(V_SYNC + V_BACK + V_DISP);
    localparam video_pkg::coord_t V_LAST     = video_pkg::coord_t'(V_TOTAL - 1);

    // counters must hold the full line and frame
    if (H_TOTAL > (1 << $bits(video_pkg::coord_t)) ||
        V_TOTAL > (1 << $bits(video_pkg::coord_t))) begin : g_width_check
        $error("video_timing_gen: timing totals do not fit the coordinate width");
    end

    // --------------------------------------------------
    // counters
    // --------------------------------------------------

    video_pkg::coord_t cnt_h;      // pixel within line
    video_pkg::coord_t cnt_v;      // line within frame
    video_pkg::coord_t nxt_h;      // cnt_h of the next clock
    video_pkg::coord_t nxt_v;      // cnt_v of the next clock
    logic              line_end;   // last pixel of a line
    logic              h_act_nxt;  // next pixel is visible
    logic              v_act_nxt;  // next line is visible

    assign line_end = (cnt_h == H_LAST);

    // wrap at H_TOTAL
    assign nxt_h = line_end ? '0 : cnt_h + 1'b1;

    // vertical only moves on line end
    always_comb begin
        if (!line_end) begin
            nxt_v = cnt_v;
        end else if (cnt_v == V_LAST) begin
            nxt_v = '0;             // frame wrap
        end else begin
            nxt_v = cnt_v + 1'b1;
        end
    end

    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_h <= '0;
            cnt_v <= '0;
        end else begin
            cnt_h <= nxt_h;
            cnt_v <= nxt_v;
        end
    end

    // --------------------------------------------------
    // sync and frame marker
    // --------------------------------------------------

    assign hs = (cnt_h >= H_SYNC_END);  // low during first H_SYNC clocks
    assign vs = (cnt_v >= V_SYNC_END);  // low during first V_SYNC lines

    // also high in reset, counters sit at zero there
    assign frame_start = (cnt_h == '0) && (cnt_v == '0);

    // --------------------------------------------------
    // request, coordinate, enable
    // --------------------------------------------------

    // look one clock ahead so the pixel source has a cycle
    assign h_act_nxt = (nxt_h >= H_ACT_BEG) && (nxt_h < H_ACT_END);
    assign v_act_nxt = (nxt_v >= V_ACT_BEG) && (nxt_v < V_ACT_END);
    assign data_req  = h_act_nxt && v_act_nxt;

    // offset into the visible area, parked at zero between requests
    always_comb begin
        if (data_req) begin
            pixel_pos.x = nxt_h - H_ACT_BEG;
            pixel_pos.y = nxt_v - V_ACT_BEG;
        end else begin
            pixel_pos.x = '0;
            pixel_pos.y = '0;
        end
    end

    // de lines up with the registered pixel
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            de <= 1'b0;
        end else begin
            de <= data_req;
        end
    end

endmodule

`default_nettype wire
